/* rtl/tcb_pkg.sv */
// TCB misaligned memory package
// bus widths, SRAM bank geometry, logarithmic size codes
// and the data word seen either as a word or as byte lanes

package tcb_pkg;

  //////////////////////////////////////////////////
  // bus and memory geometry
  //////////////////////////////////////////////////

  // data bus width and byte lanes
  localparam int unsigned DAT = 32;
  localparam int unsigned BYT = DAT / 8;
  // byte offset bits inside a word
  localparam int unsigned OFF = $clog2(BYT);
  // row address bits per bank
  localparam int unsigned ROW = 8;
  // full byte address
  localparam int unsigned ADR = ROW + OFF;
  // rows per bank
  localparam int unsigned DEPTH = 2 ** ROW;

  //////////////////////////////////////////////////
  // logarithmic size
  //////////////////////////////////////////////////

  typedef logic [1:0] tcb_siz_t;

  // 2**siz bytes, value 3 is not allowed on the bus
  localparam tcb_siz_t SIZ_BYTE    = 2'd0;
  localparam tcb_siz_t SIZ_HALF    = 2'd1;
  localparam tcb_siz_t SIZ_WORD    = 2'd2;
  localparam tcb_siz_t SIZ_ILLEGAL = 2'd3;

  // data word, whole or split into lanes (lane 0 is the LSB)
  typedef union packed {
    logic [DAT-1:0]      wrd;
    logic [BYT-1:0][7:0] byt;
  } tcb_dat_t;

endpackage: tcb_pkg

/* rtl/tcb_lane_if.sv */
// TCB byte lane SRAM interface
// one byte-wide bank port: enable, write enable, row address, data

interface tcb_lane_if
  import tcb_pkg::*;
();

  // chip enable, write enable
  logic           cen;
  logic           wen;
  // row address inside the bank
  logic [ROW-1:0] adr;
  // write and read byte
  logic [7:0]     wdt;
  logic [7:0]     rdt;

  // request side, driven by the controller
  modport ctl (
    output cen,
    output wen,
    output adr,
    output wdt
  );

  // the bank itself
  modport mem (
    input  cen,
    input  wen,
    input  adr,
    input  wdt,
    output rdt
  );

  // response side, read data only
  modport rsp (
    input  rdt
  );

endinterface: tcb_lane_if

/* rtl/tcb_lib_misaligned_memory_controller.sv */
// TCB misaligned memory controller, request stage
// rotates write data onto byte lanes, computes per-lane rows and enables,
// refuses accesses past the last row, registers the response descriptor

module tcb_lib_misaligned_memory_controller
  import tcb_pkg::*;
(
  input  logic           clk,
  input  logic           arst_n,
  // request
  input  logic           vld,
  input  logic           wen,
  input  logic [ADR-1:0] adr,
  input  tcb_siz_t       siz,
  input  logic [DAT-1:0] wdt,
  output logic           rdy,
  // SRAM lanes
  tcb_lane_if.ctl        lane [BYT-1:0],
  // response descriptor
  output logic           dsc_vld,
  output logic [OFF-1:0] dsc_off,
  output tcb_siz_t       dsc_siz,
  output logic           dsc_err
);

  //////////////////////////////////////////////////
  // local signals
  //////////////////////////////////////////////////

  // handshake
  logic           trn;
  // address split into row and byte offset
  logic [OFF-1:0] off;
  logic [ROW-1:0] row;
  logic [ROW-1:0] row_nxt;
  // per lane: request byte index, active, wrapped into next row
  logic [OFF-1:0] idx [BYT];
  logic [BYT-1:0] ena;
  logic [BYT-1:0] wrp;
  logic [BYT-1:0] cen;
  // access runs past the last row
  logic           err;
  // write data split into bytes
  tcb_dat_t       req;

  // banks never stall
  assign rdy = 1'b1;
  assign trn = vld & rdy;

  assign off     = adr[OFF-1:0];
  assign row     = adr[ADR-1:OFF];
  assign row_nxt = row + 1'b1;

  assign req.wrd = wdt;

  //////////////////////////////////////////////////
  // lane mapping
  //////////////////////////////////////////////////

  always_comb begin
    for (int unsigned i = 0; i < BYT; i++) begin
      // lane i carries request byte (i - off) mod BYT
      idx[i] = OFF'(i) - off;
      // active while byte index is below 2**siz
      ena[i] = {1'b0, idx[i]} < ((OFF+1)'(1) << siz);
      // lanes below the offset belong to the next row
      wrp[i] = OFF'(i) < off;
    end
  end

  // a wrapping lane at the last row has nowhere to go
  assign err = |(ena & wrp) & (&row);

  // no lane fires on an idle bus or on a refused access
  assign cen = {BYT{vld & ~err}} & ena;

  for (genvar i = 0; i < BYT; i++) begin: gen_lane
    assign lane[i].cen = cen[i];
    assign lane[i].wen = wen & cen[i];
    assign lane[i].adr = wrp[i] ? row_nxt : row;
    // write data rotation
    assign lane[i].wdt = req.byt[idx[i]];
  end

  //////////////////////////////////////////////////
  // response descriptor
  //////////////////////////////////////////////////

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      dsc_vld <= 1'b0;
      dsc_off <= '0;
      dsc_siz <= SIZ_BYTE;
      dsc_err <= 1'b0;
    end else begin
      dsc_vld <= trn;
      // hold last access when idle
      if (trn) begin
        dsc_off <= off;
        dsc_siz <= siz;
        dsc_err <= err;
      end
    end
  end

  //////////////////////////////////////////////////
  // assertions
  //////////////////////////////////////////////////

  // manager never issues the reserved size
  a_siz_legal: assert property (
    @(posedge clk) disable iff (!arst_n) vld |-> (siz != SIZ_ILLEGAL)
  );

  // one enabled lane per request byte
  a_lane_count: assert property (
    @(posedge clk) disable iff (!arst_n)
      (vld && !err && (siz != SIZ_ILLEGAL)) |-> ($countones(cen) == (32'd1 << siz))
  );

endmodule: tcb_lib_misaligned_memory_controller

/* rtl/tcb_sram_bank.sv */
// TCB SRAM bank
// one byte lane of memory, synchronous write and registered read

module tcb_sram_bank
  import tcb_pkg::*;
(
  input  logic    clk,
  tcb_lane_if.mem lane
);

  //////////////////////////////////////////////////
  // storage
  //////////////////////////////////////////////////

  // one byte per row
  logic [7:0] mem [DEPTH];

  always_ff @(posedge clk) begin
    if (lane.cen) begin
      if (lane.wen) begin
        mem[lane.adr] <= lane.wdt;
        // write-first, the response echoes the stored byte
        lane.rdt <= lane.wdt;
      end else begin
        lane.rdt <= mem[lane.adr];
      end
    end
  end

  //////////////////////////////////////////////////
  // assertions
  //////////////////////////////////////////////////

  // controller only writes an enabled lane
  a_wen_cen: assert property (
    @(posedge clk) lane.wen |-> lane.cen
  );

endmodule: tcb_sram_bank

/* rtl/tcb_rsp_align.sv */
// TCB response aligner
// rotates lane read data back to bus order, zeroes bytes above
// the access size and reports the refused-access status

module tcb_rsp_align
  import tcb_pkg::*;
(
  // response descriptor
  input  logic           dsc_vld,
  input  logic [OFF-1:0] dsc_off,
  input  tcb_siz_t       dsc_siz,
  input  logic           dsc_err,
  // SRAM lanes
  tcb_lane_if.rsp        lane [BYT-1:0],
  // response
  output logic           rsp_vld,
  output logic [DAT-1:0] rdt,
  output logic           sts
);

  //////////////////////////////////////////////////
  // read data rotation
  //////////////////////////////////////////////////

  // read bytes in lane order
  tcb_dat_t lane_dat;
  // read bytes in bus order
  tcb_dat_t rsp_dat;

  for (genvar i = 0; i < BYT; i++) begin: gen_lane
    assign lane_dat.byt[i] = lane[i].rdt;
  end

  always_comb begin
    // upper bytes stay zero
    rsp_dat.wrd = '0;
    for (int unsigned k = 0; k < BYT; k++) begin
      // bus byte k sits on lane (off + k) mod BYT
      if (!dsc_err && (k < (32'd1 << dsc_siz))) begin
        rsp_dat.byt[k] = lane_dat.byt[OFF'(k) + dsc_off];
      end
    end
  end

  //////////////////////////////////////////////////
  // response
  //////////////////////////////////////////////////

  assign rdt = rsp_dat.wrd;

  // error status, memory untouched
  assign sts = dsc_err;

  // one response per descriptor
  assign rsp_vld = dsc_vld;

endmodule: tcb_rsp_align

/* rtl/tcb_mmc_top.sv */
// TCB misaligned memory top level
// request stage, four byte-wide SRAM banks and the response aligner

module tcb_mmc_top
  import tcb_pkg::*;
(
  input  logic           clk,
  input  logic           arst_n,
  // request
  input  logic           vld,
  input  logic           wen,
  input  logic [ADR-1:0] adr,
  input  tcb_siz_t       siz,
  input  logic [DAT-1:0] wdt,
  output logic           rdy,
  // response
  output logic           rsp_vld,
  output logic [DAT-1:0] rdt,
  output logic           sts
);

  //////////////////////////////////////////////////
  // local signals
  //////////////////////////////////////////////////

  // one lane per bank
  tcb_lane_if lane [BYT-1:0] ();

  // descriptor, request stage to response stage
  logic           dsc_vld;
  logic [OFF-1:0] dsc_off;
  tcb_siz_t       dsc_siz;
  logic           dsc_err;

  //////////////////////////////////////////////////
  // request stage
  //////////////////////////////////////////////////

  tcb_lib_misaligned_memory_controller ctl (
    .clk     (clk),
    .arst_n  (arst_n),
    .vld     (vld),
    .wen     (wen),
    .adr     (adr),
    .siz     (siz),
    .wdt     (wdt),
    .rdy     (rdy),
    .lane    (lane),
    .dsc_vld (dsc_vld),
    .dsc_off (dsc_off),
    .dsc_siz (dsc_siz),
    .dsc_err (dsc_err)
  );

  //////////////////////////////////////////////////
  // memory banks
  //////////////////////////////////////////////////

  for (genvar i = 0; i < BYT; i++) begin: gen_bank
    tcb_sram_bank bank (
      .clk  (clk),
      .lane (lane[i])
    );
  end

  //////////////////////////////////////////////////
  // response stage
  //////////////////////////////////////////////////

  tcb_rsp_align aln (
    .dsc_vld (dsc_vld),
    .dsc_off (dsc_off),
    .dsc_siz (dsc_siz),
    .dsc_err (dsc_err),
    .lane    (lane),
    .rsp_vld (rsp_vld),
    .rdt     (rdt),
    .sts     (sts)
  );

endmodule: tcb_mmc_top

/* bench/tcb_mmc_tb.sv */
// TCB misaligned memory testbench
// directed and random requests checked against a byte-array model

module tcb_mmc_tb
  import tcb_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  //////////////////////////////////////////////////
  // request counts and run limit
  //////////////////////////////////////////////////

  localparam int unsigned MEM_BYTES   = DEPTH * BYT;
  localparam int unsigned N_FILL      = DEPTH;
  localparam int unsigned N_WORD      = 16;
  localparam int unsigned N_NARROW    = 48;
  localparam int unsigned N_CROSS     = 16;
  localparam int unsigned N_ZERO      = 9;
  localparam int unsigned N_RANGE     = 11;
  localparam int unsigned N_RAND      = 400;
  localparam int unsigned N_TOTAL     = N_FILL + N_WORD + N_NARROW + N_CROSS
                                        + N_ZERO + N_RANGE + N_RAND;
  localparam int unsigned CYCLE_LIMIT = 2 * N_TOTAL + 100;

  // bus signals
  logic           clk;
  logic           arst_n;
  logic           vld;
  logic           wen;
  logic [ADR-1:0] adr;
  tcb_siz_t       siz;
  logic [DAT-1:0] wdt;
  logic           rdy;
  logic           rsp_vld;
  logic [DAT-1:0] rdt;
  logic           sts;

  // reference memory and expected responses {sts, rdt}
  logic [7:0]     ref_mem [MEM_BYTES];
  logic [DAT:0]   exp_q [$];
  logic [31:0]    seed;
  int             err_cnt;
  int             err_mark;
  int             chk_cnt;
  int             test_cnt;
  int             fail_cnt;
  int unsigned    cycles;

  tcb_mmc_top DUT (
    .clk     (clk),
    .arst_n  (arst_n),
    .vld     (vld),
    .wen     (wen),
    .adr     (adr),
    .siz     (siz),
    .wdt     (wdt),
    .rdy     (rdy),
    .rsp_vld (rsp_vld),
    .rdt     (rdt),
    .sts     (sts)
  );

  initial clk = 1'b0;
  always #5 clk = ~clk;

  // run limit, any response still owed at this point is lost
  always @(posedge clk) begin
    cycles++;
    if (cycles >= CYCLE_LIMIT) begin
      $display("timeout after %0d cycles, %0d responses never arrived", cycles, exp_q.size());
      $display("STATUS: FAIL");
      $finish;
    end
  end

  //////////////////////////////////////////////////
  // helpers
  //////////////////////////////////////////////////

  // LCG, full period modulo 2**32
  function automatic logic [31:0] next_rand();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed;
  endfunction

  // background byte, mixes low and high address bits
  function automatic logic [7:0] fill_byte(input int unsigned a);
    return 8'(a * 7) ^ 8'((a >> 8) * 91);
  endfunction

  // model the access, queue its response, then drive it onto the bus
  task automatic issue(input logic w, input int unsigned a, input tcb_siz_t s,
                       input logic [DAT-1:0] d);
    int unsigned n;
    tcb_dat_t    din;
    tcb_dat_t    dout;
    logic        e_sts;
    n        = 1 << s;
    din.wrd  = d;
    dout.wrd = '0;
    e_sts    = 1'b0;
    // refused when the last byte lies past the end
    if (a + n > MEM_BYTES) begin
      e_sts = 1'b1;
    end else begin
      for (int k = 0; k < int'(n); k++) begin
        if (w) begin
          ref_mem[ADR'(a + k)] = din.byt[2'(k)];
        end
        dout.byt[2'(k)] = ref_mem[ADR'(a + k)];
      end
    end
    exp_q.push_back({e_sts, dout.wrd});
    @(posedge clk);
    #1;
    vld = 1'b1;
    wen = w;
    adr = ADR'(a);
    siz = s;
    wdt = d;
  endtask

  task automatic bus_idle();
    @(posedge clk);
    #1;
    vld = 1'b0;
    wen = 1'b0;
  endtask

  // idle the bus, wait for every owed response, report the test
  task automatic close_test(input string name);
    bus_idle();
    while (exp_q.size() != 0) @(negedge clk);
    test_cnt++;
    if (err_cnt == err_mark) begin
      $display("test %0d %s: ok", test_cnt, name);
    end else begin
      fail_cnt++;
      $display("test %0d %s: %0d errors", test_cnt, name, err_cnt - err_mark);
    end
    err_mark = err_cnt;
  endtask

  // write across a row boundary, read it back, then both whole rows
  task automatic cross_case(input int unsigned a, input tcb_siz_t s);
    issue(1'b1, a, s, next_rand());
    issue(1'b0, a, s, '0);
    issue(1'b0, a & ~32'd3, SIZ_WORD, '0);
    issue(1'b0, (a & ~32'd3) + 4, SIZ_WORD, '0);
  endtask

  //////////////////////////////////////////////////
  // response monitor
  //////////////////////////////////////////////////

  // mid-cycle, all response signals settled
  always @(negedge clk) begin
    logic [DAT:0] ent;
    // subordinate never pushes back
    if (vld) begin
      assert (rdy == 1'b1) else begin
        $display("[FAIL] rdy: got %h expected %h", rdy, 1'b1);
        err_cnt++;
      end
    end
    if (rsp_vld) begin
      chk_cnt++;
      assert (exp_q.size() != 0) else begin
        $display("response arrived with no request outstanding");
        err_cnt++;
      end
      if (exp_q.size() != 0) begin
        ent = exp_q.pop_front();
        assert (sts == ent[DAT]) else begin
          $display("[FAIL] sts: got %h expected %h", sts, ent[DAT]);
          err_cnt++;
        end
        assert (rdt == ent[DAT-1:0]) else begin
          $display("[FAIL] rdt: got %h expected %h", rdt, ent[DAT-1:0]);
          err_cnt++;
        end
      end
    end
  end

  //////////////////////////////////////////////////
  // test sequence
  //////////////////////////////////////////////////

  initial begin
    tcb_dat_t    fw;
    logic [31:0] r;
    arst_n   = 1'b0;
    vld      = 1'b0;
    wen      = 1'b0;
    adr      = '0;
    siz      = SIZ_BYTE;
    wdt      = '0;
    seed     = 32'd60;
    err_cnt  = 0;
    err_mark = 0;
    chk_cnt  = 0;
    test_cnt = 0;
    fail_cnt = 0;
    cycles   = 0;
    repeat (3) @(posedge clk);
    #1;
    arst_n = 1'b1;

    // known background in every byte
    for (int unsigned i = 0; i < N_FILL; i++) begin
      for (int k = 0; k < int'(BYT); k++) begin
        fw.byt[2'(k)] = fill_byte(4 * i + k);
      end
      issue(1'b1, 4 * i, SIZ_WORD, fw.wrd);
    end
    close_test("memory fill");

    // aligned words
    for (int unsigned i = 0; i < 8; i++) begin
      issue(1'b1, 4 * i, SIZ_WORD, next_rand());
    end
    for (int unsigned i = 0; i < 8; i++) begin
      issue(1'b0, 4 * i, SIZ_WORD, '0);
    end
    close_test("aligned words");

    // bytes and half-words at every offset, neighbors seen via word reads
    for (int s = 0; s < 2; s++) begin
      for (int off = 0; off < int'(BYT); off++) begin
        issue(1'b1, 64, SIZ_WORD, next_rand());
        issue(1'b1, 68, SIZ_WORD, next_rand());
        issue(1'b1, 64 + off, tcb_siz_t'(s), next_rand());
        issue(1'b0, 64 + off, tcb_siz_t'(s), '0);
        issue(1'b0, 64, SIZ_WORD, '0);
        issue(1'b0, 68, SIZ_WORD, '0);
      end
    end
    close_test("narrow offsets");

    // row crossing
    cross_case(129, SIZ_WORD);
    cross_case(130, SIZ_WORD);
    cross_case(131, SIZ_WORD);
    cross_case(131, SIZ_HALF);
    close_test("row crossing");

    // all ones underneath, upper bytes must come back zero
    issue(1'b1, 192, SIZ_WORD, 32'hffff_ffff);
    for (int s = 0; s < 2; s++) begin
      for (int off = 0; off < int'(BYT); off++) begin
        issue(1'b0, 192 + off, tcb_siz_t'(s), '0);
      end
    end
    close_test("zero fill");

    // past the last row, refused and memory left alone
    issue(1'b1, MEM_BYTES - 4, SIZ_WORD, next_rand());
    issue(1'b1, MEM_BYTES - 1, SIZ_HALF, next_rand());
    issue(1'b1, MEM_BYTES - 3, SIZ_WORD, next_rand());
    issue(1'b1, MEM_BYTES - 2, SIZ_WORD, next_rand());
    issue(1'b1, MEM_BYTES - 1, SIZ_WORD, next_rand());
    issue(1'b0, MEM_BYTES - 1, SIZ_HALF, '0);
    issue(1'b0, MEM_BYTES - 3, SIZ_WORD, '0);
    issue(1'b0, MEM_BYTES - 2, SIZ_WORD, '0);
    issue(1'b0, MEM_BYTES - 1, SIZ_WORD, '0);
    issue(1'b0, MEM_BYTES - 4, SIZ_WORD, '0);
    // wrapped lanes would land in row 0
    issue(1'b0, 0, SIZ_WORD, '0);
    close_test("out of range");

    // back-to-back mixed traffic, upper LCG bits only
    for (int unsigned i = 0; i < N_RAND; i++) begin
      r = next_rand();
      issue(r[31], 32'(r[25:16]), tcb_siz_t'(32'(r[30:27]) % 3), next_rand());
    end
    close_test("random mix");

    $display("tests %0d, failed %0d, responses %0d, errors %0d",
             test_cnt, fail_cnt, chk_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule: tcb_mmc_tb

/* verilog.f */
rtl/tcb_pkg.sv
rtl/tcb_lane_if.sv
rtl/tcb_lib_misaligned_memory_controller.sv
rtl/tcb_sram_bank.sv
rtl/tcb_rsp_align.sv
rtl/tcb_mmc_top.sv
bench/tcb_mmc_tb.sv

/* Makefile */
# Verilator build for the TCB misaligned memory controller

VERILATOR ?= verilator
TOP       ?= tcb_mmc_tb
FLIST     ?= verilog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= STATUS: PASS

SIM := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FLIST) $(shell cat $(FLIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FLIST)

run: $(SIM)
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^$(PASS_MSG)$$"

clean:
	rm -rf $(OBJ_DIR)
